//--- verilog/msx_io_pkg.sv
`default_nettype none

package msx_io_pkg;

   // upper five bits of the I/O port address
   localparam logic [4:0] io_psg_base = 5'b10100;
   localparam logic [4:0] io_ppi_base = 5'b10101;
   localparam logic [4:0] io_vdp_base = 5'b10011;

   // 8255 register select from address bits 1:0
   localparam logic [1:0] ppi_reg_a    = 2'd0;
   localparam logic [1:0] ppi_reg_b    = 2'd1;
   localparam logic [1:0] ppi_reg_c    = 2'd2;
   localparam logic [1:0] ppi_reg_ctrl = 2'd3;

   // data bus level when nothing drives a read
   localparam logic [7:0] bus_idle_data = 8'hff;

   // control word, bit 7 picks mode-set (1) or port C bit set/reset (0)
   typedef union packed {
      struct packed {
         logic       mode_set;
         logic [1:0] grp_a_mode;
         logic       port_a_in;
         logic       port_ch_in;
         logic       grp_b_mode;
         logic       port_b_in;
         logic       port_cl_in;
      } mode;
      struct packed {
         logic       mode_set;
         logic [2:0] unused;
         logic [2:0] bit_sel;
         logic       bit_val;
      } bsr;
   } ppi_ctrl_u;

endpackage

`default_nettype wire

//--- verilog/msx_audio_pkg.sv
`default_nettype none

package msx_audio_pkg;

   // source and mixer widths
   localparam int psg_level_w = 10;
   localparam int dev_sound_w = 16;
   localparam int mix_w       = 17;

   // weight of each source inside the PSG sum
   localparam int beep_shift = 5;
   localparam int cas_shift  = 4;
   // PSG sum up to mixer scale
   localparam int psg_shift  = 4;

   // clip codes of the 16 bit output
   localparam logic [15:0] audio_pos_max = 16'h7fff;
   localparam logic [15:0] audio_neg_max = 16'h8000;

endpackage

`default_nettype wire

//--- verilog/msx_cpu_bus.sv
`default_nettype none
`timescale 1ns/10ps

module msx_cpu_bus (
   input  wire logic       clk21m,
   input  wire logic       exwait_n,
   input  wire logic       ce_3m58_i,
   input  wire logic       m1_n_i,
   input  wire logic       ppi_cs_i,
   input  wire logic [1:0] page_i,
   input  wire logic [7:0] port_a_i,
   output logic            wait_n_o,
   output logic [1:0]      slot_o
);

   // wait_n_o as seen at the last ce edge
   logic wait_seen_n;
   // slot register written at least once
   logic map_valid_q;

   // one wait per opcode fetch
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         wait_n_o    <= 1'b1;
         wait_seen_n <= 1'b1;
      end else begin
         // low state already seen by the CPU, release
         if (!wait_seen_n) begin
            wait_n_o <= 1'b1;
         end else if (ce_3m58_i && !m1_n_i && wait_n_o) begin
            wait_n_o <= 1'b0;
         end
         if (ce_3m58_i) begin
            wait_seen_n <= wait_n_o;
         end
      end
   end

   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         map_valid_q <= 1'b0;
      end else if (ppi_cs_i) begin
         map_valid_q <= 1'b1;
      end
   end

   // page 0 uses port A bits 1:0, page 3 bits 7:6
   always_comb begin
      if (!map_valid_q) begin
         slot_o = 2'b00;
      end else begin
         case (page_i)
            2'd0:    slot_o = port_a_i[1:0];
            2'd1:    slot_o = port_a_i[3:2];
            2'd2:    slot_o = port_a_i[5:4];
            default: slot_o = port_a_i[7:6];
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/msx_io_decode.sv
`default_nettype none
`timescale 1ns/10ps

module msx_io_decode (
   input  wire logic [7:0] port_addr_i,
   input  wire logic       iorq_n_i,
   input  wire logic       m1_n_i,
   input  wire logic       rd_n_i,
   input  wire logic [7:0] vdp_dout_i,
   input  wire logic [7:0] psg_dout_i,
   input  wire logic [7:0] ppi_dout_i,
   input  wire logic [7:0] mem_dout_i,
   output logic            psg_cs_o,
   output logic            ppi_cs_o,
   output logic            vdp_cs_o,
   output logic [7:0]      cpu_din_o
);

   import msx_io_pkg::*;

   // I/O cycle that is not an interrupt acknowledge
   logic io_cycle;

   assign io_cycle = !iorq_n_i && m1_n_i;

   // each chip owns eight ports
   assign psg_cs_o = io_cycle && (port_addr_i[7:3] == io_psg_base);
   assign ppi_cs_o = io_cycle && (port_addr_i[7:3] == io_ppi_base);
   assign vdp_cs_o = io_cycle && (port_addr_i[7:3] == io_vdp_base);

   // read source, first match wins
   always_comb begin
      if (rd_n_i) begin
         cpu_din_o = bus_idle_data;
      end else if (vdp_cs_o) begin
         cpu_din_o = vdp_dout_i;
      end else if (psg_cs_o) begin
         cpu_din_o = psg_dout_i;
      end else if (ppi_cs_o) begin
         cpu_din_o = ppi_dout_i;
      end else begin
         // memory cycle or unmapped port
         cpu_din_o = mem_dout_i;
      end
   end

endmodule

`default_nettype wire

//--- verilog/msx_ppi.sv
`default_nettype none
`timescale 1ns/10ps

module msx_ppi (
   input  wire logic       clk21m,
   input  wire logic       exwait_n,
   input  wire logic       cs_i,
   input  wire logic       wr_n_i,
   input  wire logic [1:0] reg_i,
   input  wire logic [7:0] din_i,
   input  wire logic [7:0] kbd_data_i,
   output logic [7:0]      dout_o,
   output logic [7:0]      port_a_o,
   output logic [7:0]      port_c_o
);

   import msx_io_pkg::*;

   logic       wr_en;
   ppi_ctrl_u  ctrl_w;
   logic [7:0] port_a_q;
   logic [7:0] port_c_q;

   assign wr_en  = cs_i && !wr_n_i;
   assign ctrl_w = ppi_ctrl_u'(din_i);

   // port B is always the keyboard input, writes to it are dropped
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         port_a_q <= 8'h00;
         port_c_q <= 8'h00;
      end else if (wr_en) begin
         case (reg_i)
            ppi_reg_a: begin
               port_a_q <= din_i;
            end
            ppi_reg_c: begin
               port_c_q <= din_i;
            end
            ppi_reg_ctrl: begin
               if (ctrl_w.mode.mode_set) begin
                  // a mode change resets all outputs
                  port_a_q <= 8'h00;
                  port_c_q <= 8'h00;
               end else begin
                  port_c_q[ctrl_w.bsr.bit_sel] <= ctrl_w.bsr.bit_val;
               end
            end
            default: begin
            end
         endcase
      end
   end

   // reads of the control word float high
   always_comb begin
      case (reg_i)
         ppi_reg_a: dout_o = port_a_q;
         ppi_reg_b: dout_o = kbd_data_i;
         ppi_reg_c: dout_o = port_c_q;
         default:   dout_o = bus_idle_data;
      endcase
   end

   assign port_a_o = port_a_q;
   assign port_c_o = port_c_q;

endmodule

`default_nettype wire

//--- verilog/msx_psg_port.sv
`default_nettype none
`timescale 1ns/10ps

module msx_psg_port (
   input  wire logic       clk21m,
   input  wire logic       exwait_n,
   input  wire logic       ce_3m58_i,
   input  wire logic       psg_cs_i,
   input  wire logic [1:0] addr_i,
   input  wire logic [5:0] joy0_i,
   input  wire logic [5:0] joy1_i,
   input  wire logic [7:0] psg_iob_i,
   input  wire logic       cas_audio_i,
   output logic            psg_bdir_o,
   output logic            psg_bc1_o,
   output logic [7:0]      psg_ioa_o
);

   logic       sel_1st_q;
   logic       sel_2nd_q;
   logic       strobe;
   logic [5:0] joy_a;
   logic [5:0] joy_b;

   // active low joystick lines in PSG order, or all ones when switched off
   function automatic logic [5:0] joy_lines(input logic [5:0] joy, input logic off,
                                            input logic fire1_en, input logic fire2_en);
      logic [5:0] lines;
      lines = off ? 6'h3f : ~{joy[5], joy[4], joy[0], joy[1], joy[2], joy[3]};
      return lines & {fire2_en, fire1_en, 4'hf};
   endfunction

   // ce edges since the select went high
   always_ff @(posedge clk21m or negedge exwait_n) begin
      if (!exwait_n) begin
         sel_1st_q <= 1'b0;
         sel_2nd_q <= 1'b0;
      end else if (!psg_cs_i) begin
         sel_1st_q <= 1'b0;
         sel_2nd_q <= 1'b0;
      end else if (ce_3m58_i) begin
         sel_1st_q <= 1'b1;
         sel_2nd_q <= sel_1st_q;
      end
   end

   // strobe ends after two ce edges, apart from the ce cycle itself
   assign strobe     = psg_cs_i && (!sel_2nd_q || ce_3m58_i);
   assign psg_bdir_o = strobe && !addr_i[1];
   assign psg_bc1_o  = strobe && !addr_i[0];

   // port B bits 0..3 mask fire lines, 4/5 switch a joystick off
   assign joy_a = joy_lines(joy0_i, psg_iob_i[4], psg_iob_i[1], psg_iob_i[0]);
   assign joy_b = joy_lines(joy1_i, psg_iob_i[5], psg_iob_i[3], psg_iob_i[2]);

   assign psg_ioa_o = {cas_audio_i, 1'b0, psg_iob_i[6] ? joy_b : joy_a};

endmodule

`default_nettype wire

//--- verilog/msx_audio_mix.sv
`default_nettype none
`timescale 1ns/10ps

module msx_audio_mix (
   input  wire logic        [msx_audio_pkg::psg_level_w-1:0] psg_level_i,
   input  wire logic signed [msx_audio_pkg::dev_sound_w-1:0] dev_sound_i,
   input  wire logic                                         keybeep_i,
   input  wire logic                                         cas_motor_i,
   input  wire logic                                         cas_audio_i,
   output logic             [15:0]                           audio_o
);

   import msx_audio_pkg::*;

   logic                   cas_bit;
   logic [psg_level_w-1:0] psg_sum;
   logic [mix_w-1:0]       psg_scaled;
   logic [mix_w-1:0]       mix_sum;

   // tape monitor only while the motor relay is off
   assign cas_bit = cas_audio_i && !cas_motor_i;

   assign psg_sum = psg_level_i
                  + (psg_level_w'(keybeep_i) << beep_shift)
                  + (psg_level_w'(cas_bit) << cas_shift);

   assign psg_scaled = mix_w'(psg_sum) << psg_shift;
   assign mix_sum    = mix_w'(dev_sound_i) + psg_scaled;

   // top three bits decide between pass-through and clipping
   always_comb begin
      case (mix_sum[mix_w-1 -: 3])
         3'b000:                audio_o = {1'b0, mix_sum[mix_w-4:0], 1'b0};
         3'b111:                audio_o = {1'b1, mix_sum[mix_w-4:0], 1'b0};
         3'b001, 3'b010, 3'b011: audio_o = audio_pos_max;
         default:               audio_o = audio_neg_max;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/msx_top.sv
`default_nettype none
`timescale 1ns/10ps

module msx_top (
   input  wire logic                                         clk21m,
   input  wire logic                                         exwait_n,
   input  wire logic                                         ce_3m58_i,
   // Z80 bus
   input  wire logic        [15:0]                           cpu_addr_i,
   input  wire logic        [7:0]                            cpu_dout_i,
   input  wire logic                                         mreq_n_i,
   input  wire logic                                         iorq_n_i,
   input  wire logic                                         rd_n_i,
   input  wire logic                                         wr_n_i,
   input  wire logic                                         m1_n_i,
   output wire logic        [7:0]                            cpu_din_o,
   output wire logic                                         wait_n_o,
   // read data from outside chips
   input  wire logic        [7:0]                            mem_dout_i,
   input  wire logic        [7:0]                            vdp_dout_i,
   input  wire logic        [7:0]                            psg_dout_i,
   output wire logic                                         vdp_cs_o,
   // PSG bus and I/O ports
   output wire logic                                         psg_bdir_o,
   output wire logic                                         psg_bc1_o,
   output wire logic        [7:0]                            psg_ioa_o,
   input  wire logic        [7:0]                            psg_iob_i,
   input  wire logic        [msx_audio_pkg::psg_level_w-1:0] psg_level_i,
   // keyboard matrix
   input  wire logic        [7:0]                            kbd_data_i,
   output wire logic        [3:0]                            kbd_row_o,
   input  wire logic        [5:0]                            joy0_i,
   input  wire logic        [5:0]                            joy1_i,
   // tape, slots and sound
   input  wire logic                                         cas_audio_i,
   output wire logic                                         cas_motor_o,
   output wire logic        [1:0]                            slot_o,
   input  wire logic signed [msx_audio_pkg::dev_sound_w-1:0] dev_sound_i,
   output wire logic        [15:0]                           audio_o
);

   wire       psg_cs;
   wire       ppi_cs;
   wire [7:0] ppi_dout;
   wire [7:0] port_a;
   wire [7:0] port_c;

   msx_io_decode u_io_decode (
      .port_addr_i (cpu_addr_i[7:0]),
      .iorq_n_i    (iorq_n_i),
      .m1_n_i      (m1_n_i),
      .rd_n_i      (rd_n_i),
      .vdp_dout_i  (vdp_dout_i),
      .psg_dout_i  (psg_dout_i),
      .ppi_dout_i  (ppi_dout),
      .mem_dout_i  (mem_dout_i),
      .psg_cs_o    (psg_cs),
      .ppi_cs_o    (ppi_cs),
      .vdp_cs_o    (vdp_cs_o),
      .cpu_din_o   (cpu_din_o)
   );

   msx_ppi u_ppi (
      .clk21m     (clk21m),
      .exwait_n   (exwait_n),
      .cs_i       (ppi_cs),
      .wr_n_i     (wr_n_i),
      .reg_i      (cpu_addr_i[1:0]),
      .din_i      (cpu_dout_i),
      .kbd_data_i (kbd_data_i),
      .dout_o     (ppi_dout),
      .port_a_o   (port_a),
      .port_c_o   (port_c)
   );

   // port C low nibble selects the keyboard row
   assign kbd_row_o   = port_c[3:0];
   assign cas_motor_o = port_c[4];

   msx_cpu_bus u_cpu_bus (
      .clk21m    (clk21m),
      .exwait_n  (exwait_n),
      .ce_3m58_i (ce_3m58_i),
      .m1_n_i    (m1_n_i),
      .ppi_cs_i  (ppi_cs),
      .page_i    (cpu_addr_i[15:14]),
      .port_a_i  (port_a),
      .wait_n_o  (wait_n_o),
      .slot_o    (slot_o)
   );

   msx_psg_port u_psg_port (
      .clk21m      (clk21m),
      .exwait_n    (exwait_n),
      .ce_3m58_i   (ce_3m58_i),
      .psg_cs_i    (psg_cs),
      .addr_i      (cpu_addr_i[1:0]),
      .joy0_i      (joy0_i),
      .joy1_i      (joy1_i),
      .psg_iob_i   (psg_iob_i),
      .cas_audio_i (cas_audio_i),
      .psg_bdir_o  (psg_bdir_o),
      .psg_bc1_o   (psg_bc1_o),
      .psg_ioa_o   (psg_ioa_o)
   );

   // key click is port C bit 7
   msx_audio_mix u_audio_mix (
      .psg_level_i (psg_level_i),
      .dev_sound_i (dev_sound_i),
      .keybeep_i   (port_c[7]),
      .cas_motor_i (port_c[4]),
      .cas_audio_i (cas_audio_i),
      .audio_o     (audio_o)
   );

endmodule

`default_nettype wire

//--- test/tb_msx_model.svh
`ifndef TB_MSX_MODEL_SVH
`define TB_MSX_MODEL_SVH

// a chip owns eight ports from base*8, M1 low marks an interrupt acknowledge
function automatic logic cs_model(input logic [7:0] port, input logic iorq_n,
                                  input logic m1_n, input logic [4:0] base);
   return !iorq_n && m1_n && (port >= {base, 3'd0}) && (port <= {base, 3'd7});
endfunction

function automatic logic [7:0] ppi_read_model(input logic [1:0] r, input logic [7:0] a,
                                              input logic [7:0] c, input logic [7:0] kbd);
   case (r)
      2'd0:    return a;
      2'd1:    return kbd;
      2'd2:    return c;
      default: return 8'hff;
   endcase
endfunction

// read priority VDP, PSG, PPI, then memory
function automatic logic [7:0] din_model(input logic [7:0] port, input logic iorq_n,
                                         input logic m1_n, input logic rd_n,
                                         input logic [7:0] vdp, input logic [7:0] psg,
                                         input logic [7:0] ppi, input logic [7:0] mem);
   if (rd_n) begin
      return 8'hff;
   end else if (cs_model(port, iorq_n, m1_n, io_vdp_base)) begin
      return vdp;
   end else if (cs_model(port, iorq_n, m1_n, io_psg_base)) begin
      return psg;
   end else if (cs_model(port, iorq_n, m1_n, io_ppi_base)) begin
      return ppi;
   end
   return mem;
endfunction

// port A and port C after one register write, returned as {a, c}
function automatic logic [15:0] ppi_model(input logic [1:0] r, input logic [7:0] d,
                                          input logic [7:0] a, input logic [7:0] c);
   logic [7:0] na;
   logic [7:0] nc;
   na = a;
   nc = c;
   if (r == 2'd0) begin
      na = d;
   end else if (r == 2'd2) begin
      nc = d;
   end else if (r == 2'd3 && d[7]) begin
      na = 8'h00;
      nc = 8'h00;
   end else if (r == 2'd3) begin
      nc[d[3:1]] = d[0];
   end
   return {na, nc};
endfunction

function automatic logic [1:0] slot_model(input logic valid, input logic [7:0] a,
                                          input logic [1:0] page);
   logic [7:0] field;
   field = a >> {page, 1'b0};
   return valid ? field[1:0] : 2'b00;
endfunction

// joystick inputs are fire2 fire1 up down left right, PSG wants fire2 fire1 right left down up
function automatic logic [7:0] joy_model(input logic [5:0] joy0, input logic [5:0] joy1,
                                         input logic [7:0] iob, input logic cas);
   logic [5:0] j;
   logic [5:0] lines;
   j = iob[6] ? joy1 : joy0;
   lines = ~{j[5], j[4], j[0], j[1], j[2], j[3]};
   if (iob[6] ? iob[5] : iob[4]) begin
      lines = 6'h3f;
   end
   // fire masks, bits 1:0 for the first port and 3:2 for the second
   lines[5] = lines[5] & (iob[6] ? iob[2] : iob[0]);
   lines[4] = lines[4] & (iob[6] ? iob[3] : iob[1]);
   return {cas, 1'b0, lines};
endfunction

function automatic logic [15:0] audio_model(input logic [9:0] psg, input logic signed [15:0] dev,
                                            input logic beep, input logic motor,
                                            input logic cas);
   int psg_sum;
   int mix;
   // the PSG sum is only ten bits wide
   psg_sum = (int'(psg) + (beep ? 32 : 0) + ((cas && !motor) ? 16 : 0)) % 1024;
   mix = int'(dev) + psg_sum * 16;
   if (mix >= 16384) begin
      return 16'h7fff;
   end else if (mix < -16384) begin
      return 16'h8000;
   end
   return 16'(mix * 2);
endfunction

`endif

//--- test/tb_msx_top.sv
`default_nettype none
`timescale 1ns/10ps

module tb_msx_top;

   import msx_io_pkg::*;
   import msx_audio_pkg::*;

   `include "tb_msx_model.svh"

   // iterations per test
   localparam int n_slot   = 128;
   localparam int n_decode = 400;
   localparam int n_ppi    = 200;
   localparam int n_audio  = 400;
   localparam int n_joy    = 200;
   localparam int n_wait   = 24;
   localparam int n_strobe = 40;
   // worst case cycles per iteration, times two
   localparam int cycle_limit = 2 * (2 * n_slot + n_decode + 3 * n_ppi + 2 * n_audio + n_joy
                                     + 30 * n_wait + 18 * n_strobe + 4);

   logic                          clk21m;
   logic                          exwait_n;
   logic                          ce_3m58;
   logic [15:0]                   cpu_addr;
   logic [7:0]                    cpu_dout;
   logic                          mreq_n, iorq_n, rd_n, wr_n, m1_n;
   logic [7:0]                    mem_dout, vdp_dout, psg_dout, psg_iob, kbd_data;
   logic [psg_level_w-1:0]        psg_level;
   logic signed [dev_sound_w-1:0] dev_sound;
   logic [5:0]                    joy0, joy1;
   logic                          cas_audio;
   logic [7:0]                    cpu_din, psg_ioa;
   logic                          wait_n, vdp_cs, psg_bdir, psg_bc1, cas_motor;
   logic [3:0]                    kbd_row;
   logic [1:0]                    slot;
   logic [15:0]                   audio;

   integer     seed;
   logic [2:0] ce_cnt;
   // previous rising edge was a ce edge
   logic       ce_edge;
   logic [7:0] exp_port_a;
   logic [7:0] exp_port_c;
   logic       slot_mapped;
   int         n_tests = 0;
   int         n_checks = 0;
   int         n_errors = 0;
   int         checks_mark = 0;
   int         errors_mark = 0;
   int         n_cycles = 0;

   msx_top u_dut (
      .clk21m (clk21m), .exwait_n (exwait_n), .ce_3m58_i (ce_3m58),
      .cpu_addr_i (cpu_addr), .cpu_dout_i (cpu_dout), .mreq_n_i (mreq_n),
      .iorq_n_i (iorq_n), .rd_n_i (rd_n), .wr_n_i (wr_n), .m1_n_i (m1_n),
      .cpu_din_o (cpu_din), .wait_n_o (wait_n), .mem_dout_i (mem_dout),
      .vdp_dout_i (vdp_dout), .psg_dout_i (psg_dout), .vdp_cs_o (vdp_cs),
      .psg_bdir_o (psg_bdir), .psg_bc1_o (psg_bc1), .psg_ioa_o (psg_ioa),
      .psg_iob_i (psg_iob), .psg_level_i (psg_level), .kbd_data_i (kbd_data),
      .kbd_row_o (kbd_row), .joy0_i (joy0), .joy1_i (joy1), .cas_audio_i (cas_audio),
      .cas_motor_o (cas_motor), .slot_o (slot), .dev_sound_i (dev_sound), .audio_o (audio)
   );

   initial begin
      clk21m = 1'b0;
      forever #5 clk21m = ~clk21m;
   end

   always @(posedge clk21m) begin
      n_cycles <= n_cycles + 1;
      if (n_cycles == cycle_limit) begin
         $display("timeout: no result after %0d clock cycles", cycle_limit);
         $display("** FAIL **");
         $finish;
      end
   end

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("FAIL %0t ns: %s got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic report_test(input string name);
      n_tests++;
      $display("test %-8s %0d checks, %0d errors", name, n_checks - checks_mark,
               n_errors - errors_mark);
      checks_mark = n_checks;
      errors_mark = n_errors;
   endtask

   // falling edge, ce pulses one cycle in six
   task automatic tick();
      @(negedge clk21m);
      ce_edge = ce_3m58;
      ce_cnt  = (ce_cnt == 3'd5) ? 3'd0 : ce_cnt + 3'd1;
      ce_3m58 = (ce_cnt == 3'd5);
   endtask

   task automatic wait_ce();
      do begin
         tick();
      end while (!ce_edge);
   endtask

   task automatic bus_idle();
      mreq_n = 1'b1;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      wr_n   = 1'b1;
      m1_n   = 1'b1;
   endtask

   task automatic drive_io(input logic [7:0] port, input logic rd, input logic [7:0] data);
      cpu_addr = {8'($random(seed)), port};
      cpu_dout = data;
      mreq_n   = 1'b1;
      iorq_n   = 1'b0;
      rd_n     = !rd;
      wr_n     = rd;
      m1_n     = 1'b1;
   endtask

   task automatic ppi_write(input logic [1:0] r, input logic [7:0] data);
      tick();
      drive_io({io_ppi_base, 1'b0, r}, 1'b0, data);
      tick();
      bus_idle();
      {exp_port_a, exp_port_c} = ppi_model(r, data, exp_port_a, exp_port_c);
      slot_mapped = 1'b1;
   endtask

   task automatic slot_test();
      for (int i = 0; i < n_slot; i++) begin
         // second half runs with the slot register programmed
         if (i >= n_slot / 2 && i % 16 == 0) begin
            ppi_write(ppi_reg_a, 8'($random(seed)));
         end
         tick();
         bus_idle();
         cpu_addr = 16'($random(seed));
         mreq_n   = 1'b0;
         rd_n     = 1'($random(seed));
         #1;
         check("slot_o", 32'(slot), 32'(slot_model(slot_mapped, exp_port_a, cpu_addr[15:14])));
      end
      report_test("slot");
   endtask

   task automatic decode_test();
      logic [4:0] base;
      logic [7:0] port;
      logic [7:0] exp_din;
      for (int i = 0; i < n_decode; i++) begin
         tick();
         case (2'($random(seed)))
            2'd0:    base = io_vdp_base;
            2'd1:    base = io_psg_base;
            2'd2:    base = io_ppi_base;
            default: base = 5'($random(seed));
         endcase
         port     = {base, 3'($random(seed))};
         cpu_addr = {8'($random(seed)), port};
         iorq_n   = 1'($random(seed));
         m1_n     = 1'($random(seed));
         rd_n     = 1'($random(seed));
         vdp_dout = 8'($random(seed));
         psg_dout = 8'($random(seed));
         mem_dout = 8'($random(seed));
         kbd_data = 8'($random(seed));
         #1;
         exp_din = din_model(port, iorq_n, m1_n, rd_n, vdp_dout, psg_dout,
                             ppi_read_model(port[1:0], exp_port_a, exp_port_c, kbd_data),
                             mem_dout);
         check("vdp_cs_o", 32'(vdp_cs), 32'(cs_model(port, iorq_n, m1_n, io_vdp_base)));
         check("cpu_din_o", 32'(cpu_din), 32'(exp_din));
      end
      bus_idle();
      report_test("decode");
   endtask

   task automatic ppi_test();
      logic [2:0] op;
      logic [7:0] data;
      logic [1:0] r;
      for (int i = 0; i < n_ppi; i++) begin
         op   = 3'($random(seed));
         data = 8'($random(seed));
         // mostly data writes and bit set/reset, mode-set one time in eight
         if (op < 3'd2) begin
            ppi_write(ppi_reg_a, data);
         end else if (op < 3'd4) begin
            ppi_write(ppi_reg_c, data);
         end else begin
            ppi_write(ppi_reg_ctrl, {op == 3'd7, data[6:0]});
         end
         tick();
         r        = 2'($random(seed));
         kbd_data = 8'($random(seed));
         drive_io({io_ppi_base, 1'b0, r}, 1'b1, 8'h00);
         #1;
         check("ppi read", 32'(cpu_din), 32'(ppi_read_model(r, exp_port_a, exp_port_c, kbd_data)));
         check("kbd_row_o", 32'(kbd_row), 32'(exp_port_c[3:0]));
         check("cas_motor_o", 32'(cas_motor), 32'(exp_port_c[4]));
      end
      report_test("ppi");
   endtask

   task automatic audio_test();
      logic [15:0] exp_audio;
      int          n_pos_clip;
      int          n_neg_clip;
      n_pos_clip = 0;
      n_neg_clip = 0;
      for (int i = 0; i < n_audio; i++) begin
         // key beep and motor come from port C
         if (i % 8 == 0) begin
            ppi_write(ppi_reg_c, 8'($random(seed)));
         end
         tick();
         psg_level = 10'($random(seed));
         dev_sound = 16'($random(seed));
         cas_audio = 1'($random(seed));
         #1;
         exp_audio = audio_model(psg_level, dev_sound, exp_port_c[7], exp_port_c[4], cas_audio);
         if (exp_audio == 16'h7fff) begin
            n_pos_clip++;
         end
         if (exp_audio == 16'h8000) begin
            n_neg_clip++;
         end
         check("audio_o", 32'(audio), 32'(exp_audio));
      end
      if (n_pos_clip == 0 || n_neg_clip == 0) begin
         $display("audio test did not reach both clip codes");
         n_errors++;
      end
      report_test("audio");
   endtask

   task automatic joy_test();
      for (int i = 0; i < n_joy; i++) begin
         tick();
         joy0      = 6'($random(seed));
         joy1      = 6'($random(seed));
         psg_iob   = 8'($random(seed));
         cas_audio = 1'($random(seed));
         #1;
         check("psg_ioa_o", 32'(psg_ioa), 32'(joy_model(joy0, joy1, psg_iob, cas_audio)));
      end
      report_test("joystick");
   endtask

   task automatic wait_test();
      int k;
      for (int i = 0; i < n_wait; i++) begin
         bus_idle();
         // a full ce period with M1 high lets the wait logic settle
         wait_ce();
         wait_ce();
         check("wait_n_o before M1", 32'(wait_n), 32'd1);
         cpu_addr = 16'($random(seed));
         mreq_n   = 1'b0;
         rd_n     = 1'b0;
         m1_n     = 1'b0;
         wait_ce();
         do begin
            check("wait_n_o during M1", 32'(wait_n), 32'd0);
            check("psg_bdir_o unselected", 32'(psg_bdir), 32'd0);
            check("psg_bc1_o unselected", 32'(psg_bc1), 32'd0);
            tick();
         end while (!ce_edge);
         check("wait_n_o at next ce edge", 32'(wait_n), 32'd0);
         bus_idle();
         k = 0;
         while (!wait_n && k < 6) begin
            tick();
            k++;
         end
         check("wait_n_o released", 32'(wait_n), 32'd1);
      end
      report_test("wait");
   endtask

   task automatic strobe_test();
      logic [7:0] port;
      for (int i = 0; i < n_strobe; i++) begin
         tick();
         bus_idle();
         tick();
         port = {io_psg_base, 3'($random(seed))};
         drive_io(port, 1'($random(seed)), 8'($random(seed)));
         #1;
         check("psg_bdir_o first cycle", 32'(psg_bdir), 32'(!port[1]));
         check("psg_bc1_o first cycle", 32'(psg_bc1), 32'(!port[0]));
         repeat (int'(4'($random(seed)))) tick();
         tick();
         drive_io({io_vdp_base, 3'($random(seed))}, 1'b1, 8'h00);
         #1;
         check("psg_bdir_o unselected", 32'(psg_bdir), 32'd0);
         check("psg_bc1_o unselected", 32'(psg_bc1), 32'd0);
      end
      bus_idle();
      report_test("strobe");
   endtask

   initial begin
      seed        = 32'hbf88;
      ce_cnt      = 3'd0;
      ce_3m58     = 1'b0;
      ce_edge     = 1'b0;
      exwait_n    = 1'b0;
      cpu_addr    = 16'h0000;
      cpu_dout    = 8'h00;
      mem_dout    = 8'h00;
      vdp_dout    = 8'h00;
      psg_dout    = 8'h00;
      psg_iob     = 8'hff;
      kbd_data    = 8'hff;
      psg_level   = '0;
      dev_sound   = '0;
      joy0        = 6'h00;
      joy1        = 6'h00;
      cas_audio   = 1'b0;
      exp_port_a  = 8'h00;
      exp_port_c  = 8'h00;
      slot_mapped = 1'b0;
      bus_idle();
      repeat (2) tick();
      exwait_n = 1'b1;
      // slot test first, any PPI access sets the map flag
      slot_test();
      decode_test();
      ppi_test();
      audio_test();
      joy_test();
      wait_test();
      strobe_test();
      tick();
      $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+test
verilog/msx_io_pkg.sv
verilog/msx_audio_pkg.sv
verilog/msx_cpu_bus.sv
verilog/msx_io_decode.sv
verilog/msx_ppi.sv
verilog/msx_psg_port.sv
verilog/msx_audio_mix.sv
verilog/msx_top.sv
test/tb_msx_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -j 0 \
   --top-module tb_msx_top --Mdir obj_dir -f verilog.f

out="$(./obj_dir/Vtb_msx_top)"
echo "$out"

if grep -qF '** PASS **' <<< "$out"; then
   exit 0
fi
exit 1
